//--- hdl/axi_sram_pkg.sv
package axi_sram_pkg;

  localparam int AXI_AW   = 16;
  localparam int AXI_DW   = 16;
  localparam int AXI_IW   = 4;
  localparam int STRB_W   = 2;
  localparam int WORD_LSB = 1;
  localparam int SRAM_AW  = 15;

  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] RESP_OKAY   = 2'b00;

  // AW or AR request
  typedef struct packed {
    logic [AXI_IW-1:0] id;
    logic [AXI_AW-1:0] addr;
    logic [7:0]        len;
    logic [1:0]        burst;
  } axi_addr_t;

  typedef struct packed {
    logic [AXI_DW-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_IW-1:0] id;
    logic [1:0]        resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_IW-1:0] id;
    logic [AXI_DW-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } axi_r_t;

  // Rides along with a read, returned unchanged
  typedef struct packed {
    logic [AXI_IW-1:0] id;
    logic              last;
  } sram_meta_t;

  typedef struct packed {
    logic               wr_en;
    logic [SRAM_AW-1:0] addr;
    logic [AXI_DW-1:0]  wr_data;
    logic [STRB_W-1:0]  wr_strb;
    sram_meta_t         meta;
  } sram_cmd_t;

  typedef struct packed {
    logic [AXI_DW-1:0] data;
    sram_meta_t        meta;
  } sram_rsp_t;

endpackage

//--- hdl/axi_burst_addr.sv
module axi_burst_addr (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             load,
  input  axi_sram_pkg::axi_addr_t          req,
  input  logic                             step,
  output logic [axi_sram_pkg::SRAM_AW-1:0] addr,
  output logic                             last
);
  import axi_sram_pkg::*;

  logic [7:0] beats_left;
  logic       fixed;
  logic       spent;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beats_left <= '0;
      fixed      <= 1'b0;
      spent      <= 1'b1;
    end else if (load) begin
      beats_left <= req.len;
      // WRAP falls through to INCR here
      fixed      <= (req.burst == BURST_FIXED);
      spent      <= 1'b0;
    end else if (step) begin
      beats_left <= beats_left - 8'd1;
      spent      <= last;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      addr <= req.addr[WORD_LSB +: SRAM_AW];
    end else if (step && !fixed) begin
      addr <= addr + SRAM_AW'(1);
    end
  end

  assign last = (beats_left == 8'd0);

  // Once the final beat has gone, the next step must follow a new load
  a_no_step_past_last : assert property (
    @(posedge clk) disable iff (!rst_n) (step && !load) |-> !spent
  );

endmodule

//--- hdl/axi_wr_ctrl.sv
module axi_wr_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  axi_sram_pkg::axi_addr_t aw,
  input  logic                    w_valid,
  output logic                    w_ready,
  input  axi_sram_pkg::axi_w_t    w,
  output logic                    b_valid,
  input  logic                    b_ready,
  output axi_sram_pkg::axi_b_t    b,
  output logic                    cmd_valid,
  input  logic                    cmd_ready,
  output axi_sram_pkg::sram_cmd_t cmd
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {IDLE, DATA, RESP} state_t;

  state_t             state;
  logic [AXI_IW-1:0]  id_q;
  logic [SRAM_AW-1:0] beat_addr;
  logic               beat_last;
  logic               aw_fire;
  logic               w_fire;

  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;

  axi_burst_addr u_burst_addr (
    .clk  (clk),
    .rst_n(rst_n),
    .load (aw_fire),
    .req  (aw),
    .step (w_fire),
    .addr (beat_addr),
    .last (beat_last)
  );

  assign aw_ready = (state == IDLE);
  // W beats go straight through to the SRAM port
  assign cmd_valid = (state == DATA) && w_valid;
  assign w_ready   = (state == DATA) && cmd_ready;
  assign b_valid   = (state == RESP);
  assign b         = '{id: id_q, resp: RESP_OKAY};

  always_comb begin
    cmd         = '0;
    cmd.wr_en   = 1'b1;
    cmd.addr    = beat_addr;
    cmd.wr_data = w.data;
    cmd.wr_strb = w.strb;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (aw_fire) state <= DATA;
        DATA: if (w_fire && w.last) state <= RESP;
        RESP: if (b_ready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q <= aw.id;
    end
  end

  // Master's wlast must match the beat count from awlen
  a_wlast_matches_len : assert property (
    @(posedge clk) disable iff (!rst_n) w_fire |-> (w.last == beat_last)
  );

endmodule

//--- hdl/axi_rd_ctrl.sv
module axi_rd_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  axi_sram_pkg::axi_addr_t ar,
  output logic                    r_valid,
  input  logic                    r_ready,
  output axi_sram_pkg::axi_r_t    r,
  output logic                    cmd_valid,
  input  logic                    cmd_ready,
  output axi_sram_pkg::sram_cmd_t cmd,
  input  logic                    rsp_valid,
  output logic                    rsp_ready,
  input  axi_sram_pkg::sram_rsp_t rsp
);
  import axi_sram_pkg::*;

  typedef enum logic [1:0] {IDLE, ISSUE, DRAIN} state_t;

  state_t             state;
  logic [AXI_IW-1:0]  id_q;
  logic [SRAM_AW-1:0] beat_addr;
  logic               beat_last;
  logic               ar_fire;
  logic               cmd_fire;
  logic               r_fire;

  assign ar_fire  = ar_valid && ar_ready;
  assign cmd_fire = cmd_valid && cmd_ready;
  assign r_fire   = r_valid && r_ready;

  axi_burst_addr u_burst_addr (
    .clk  (clk),
    .rst_n(rst_n),
    .load (ar_fire),
    .req  (ar),
    .step (cmd_fire),
    .addr (beat_addr),
    .last (beat_last)
  );

  assign ar_ready  = (state == IDLE);
  assign cmd_valid = (state == ISSUE);

  always_comb begin
    cmd           = '0;
    cmd.addr      = beat_addr;
    cmd.meta.id   = id_q;
    cmd.meta.last = beat_last;
  end

  // Responses map one to one onto R beats
  assign r_valid   = rsp_valid;
  assign rsp_ready = r_ready;
  assign r         = '{id: rsp.meta.id, data: rsp.data, resp: RESP_OKAY, last: rsp.meta.last};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:  if (ar_fire) state <= ISSUE;
        ISSUE: if (cmd_fire && beat_last) state <= DRAIN;
        DRAIN: if (r_fire && r.last) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q <= ar.id;
    end
  end

endmodule

//--- hdl/sram_cmd_arb.sv
module sram_cmd_arb (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_valid,
  output logic                    wr_ready,
  input  axi_sram_pkg::sram_cmd_t wr_cmd,
  input  logic                    rd_valid,
  output logic                    rd_ready,
  input  axi_sram_pkg::sram_cmd_t rd_cmd,
  output logic                    mem_valid,
  input  logic                    mem_ready,
  output axi_sram_pkg::sram_cmd_t mem_cmd
);
  import axi_sram_pkg::*;

  logic wr_won_last;
  logic contested;
  logic grant_wr;
  logic grant_rd;

  assign contested = wr_valid && rd_valid;

  // On contention the side that lost last time goes first
  assign grant_wr = wr_valid && (!rd_valid || !wr_won_last);
  assign grant_rd = rd_valid && !grant_wr;

  assign mem_valid = wr_valid || rd_valid;
  assign mem_cmd   = grant_wr ? wr_cmd : rd_cmd;
  assign wr_ready  = mem_ready && grant_wr;
  assign rd_ready  = mem_ready && grant_rd;

  // Only a contested cycle that actually transfers flips the priority
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_won_last <= 1'b0;
    end else if (contested && mem_ready) begin
      wr_won_last <= grant_wr;
    end
  end

  a_one_ready : assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0({wr_ready, rd_ready})
  );

endmodule

//--- hdl/sram_model_mem.sv
module sram_model_mem #(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  axi_sram_pkg::sram_cmd_t cmd,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output axi_sram_pkg::sram_rsp_t rsp
);
  import axi_sram_pkg::*;

  localparam int DEPTH = 2 ** MEM_ADDR_BITS;

  logic [AXI_DW-1:0]        mem [DEPTH];
  logic [MEM_ADDR_BITS-1:0] idx;
  logic                     cmd_fire;

  // Address wraps on the memory depth
  assign idx       = cmd.addr[MEM_ADDR_BITS-1:0];
  assign cmd_ready = !rsp_valid || rsp_ready;
  assign cmd_fire  = cmd_valid && cmd_ready;

  always_ff @(posedge clk) begin
    if (cmd_fire && cmd.wr_en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (cmd.wr_strb[i]) begin
          mem[idx][8*i +: 8] <= cmd.wr_data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire && !cmd.wr_en) begin
      rsp.data <= mem[idx];
      rsp.meta <= cmd.meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (cmd_fire && !cmd.wr_en) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  a_rsp_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
  );

endmodule

//--- hdl/axi_sram_top.sv
module axi_sram_top #(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    aw_valid,
  output logic                    aw_ready,
  input  axi_sram_pkg::axi_addr_t aw,
  input  logic                    w_valid,
  output logic                    w_ready,
  input  axi_sram_pkg::axi_w_t    w,
  output logic                    b_valid,
  input  logic                    b_ready,
  output axi_sram_pkg::axi_b_t    b,
  input  logic                    ar_valid,
  output logic                    ar_ready,
  input  axi_sram_pkg::axi_addr_t ar,
  output logic                    r_valid,
  input  logic                    r_ready,
  output axi_sram_pkg::axi_r_t    r
);
  import axi_sram_pkg::*;

  logic      wr_cmd_valid;
  logic      wr_cmd_ready;
  sram_cmd_t wr_cmd;
  logic      rd_cmd_valid;
  logic      rd_cmd_ready;
  sram_cmd_t rd_cmd;
  logic      mem_cmd_valid;
  logic      mem_cmd_ready;
  sram_cmd_t mem_cmd;
  logic      mem_rsp_valid;
  logic      rd_rsp_ready;
  sram_rsp_t mem_rsp;

  axi_wr_ctrl u_wr_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw       (aw),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w        (w),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b),
    .cmd_valid(wr_cmd_valid),
    .cmd_ready(wr_cmd_ready),
    .cmd      (wr_cmd)
  );

  axi_rd_ctrl u_rd_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r),
    .cmd_valid(rd_cmd_valid),
    .cmd_ready(rd_cmd_ready),
    .cmd      (rd_cmd),
    .rsp_valid(mem_rsp_valid),
    .rsp_ready(rd_rsp_ready),
    .rsp      (mem_rsp)
  );

  sram_cmd_arb u_arb (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (wr_cmd_valid),
    .wr_ready (wr_cmd_ready),
    .wr_cmd   (wr_cmd),
    .rd_valid (rd_cmd_valid),
    .rd_ready (rd_cmd_ready),
    .rd_cmd   (rd_cmd),
    .mem_valid(mem_cmd_valid),
    .mem_ready(mem_cmd_ready),
    .mem_cmd  (mem_cmd)
  );

  sram_model_mem #(
    .MEM_ADDR_BITS(MEM_ADDR_BITS)
  ) u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_valid(mem_cmd_valid),
    .cmd_ready(mem_cmd_ready),
    .cmd      (mem_cmd),
    .rsp_valid(mem_rsp_valid),
    .rsp_ready(rd_rsp_ready),
    .rsp      (mem_rsp)
  );

endmodule

//--- dv/axi_sram_tests.svh
task automatic write_burst(input logic [AXI_IW-1:0] wr_id, input logic [AXI_AW-1:0] start_addr,
                           input int len, input logic [1:0] burst);
  axi_addr_t                req;
  logic [MEM_ADDR_BITS-1:0] idx;
  req = '{id: wr_id, addr: start_addr, len: 8'(len), burst: burst};
  // FIXED beats land on one word, so the last one wins
  for (int i = 0; i <= len; i++) begin
    idx         = word_index(start_addr, i, burst);
    sb_mem[idx] = merge_bytes(sb_mem[idx], beat_data[8'(i)], beat_strb[8'(i)]);
  end
  fork
    send_aw(req);
    send_w_beats(len);
    recv_b(wr_id);
  join
endtask

task automatic read_burst(input logic [AXI_IW-1:0] rd_id, input logic [AXI_AW-1:0] start_addr,
                          input int len, input logic [1:0] burst, input bit random_ready);
  axi_addr_t req;
  req = '{id: rd_id, addr: start_addr, len: 8'(len), burst: burst};
  fork
    send_ar(req);
    recv_r(start_addr, len, burst, rd_id, random_ready);
  join
endtask

task automatic fill_words(input logic [AXI_IW-1:0] wr_id, input logic [AXI_AW-1:0] start_addr,
                          input int count);
  for (int i = 0; i < count; i++) begin
    beat_data[8'(i)] = fill_word(word_index(start_addr, i, BURST_INCR));
    beat_strb[8'(i)] = 2'b11;
  end
  write_burst(wr_id, start_addr, count - 1, BURST_INCR);
endtask

task automatic test_reset_values();
  test_name = "reset_values";
  #1;
  check_bit({test_name, " awready"}, 1'b1, aw_ready);
  check_bit({test_name, " arready"}, 1'b1, ar_ready);
  check_bit({test_name, " bvalid"}, 1'b0, b_valid);
  check_bit({test_name, " rvalid"}, 1'b0, r_valid);
  check_bit({test_name, " wready"}, 1'b0, w_ready);
endtask

task automatic test_single_partial();
  test_name = "single_partial";
  fill_words(4'h1, 16'h0020, 1);
  // Upper byte only
  beat_data[0] = 16'h7e00;
  beat_strb[0] = 2'b10;
  write_burst(4'h2, 16'h0020, 0, BURST_INCR);
  read_burst(4'h5, 16'h0020, 0, BURST_INCR, 1'b0);
endtask

task automatic test_w_before_aw();
  axi_addr_t req;
  test_name    = "w_before_aw";
  req          = '{id: 4'h6, addr: 16'h0042, len: 8'd0, burst: BURST_INCR};
  beat_data[0] = 16'h1357;
  beat_strb[0] = 2'b11;
  sb_mem[word_index(req.addr, 0, BURST_INCR)] = beat_data[0];
  fork
    send_w_beats(0);
    begin
      repeat (3) begin
        @(negedge clk);
        #1;
        check_bit({test_name, " wready"}, 1'b0, w_ready);
        check_bit({test_name, " bvalid"}, 1'b0, b_valid);
      end
      send_aw(req);
    end
    recv_b(4'h6);
  join
  read_burst(4'h7, 16'h0042, 0, BURST_INCR, 1'b0);
endtask

task automatic test_incr_burst();
  test_name    = "incr_burst";
  beat_data[0] = 16'h0a11;
  beat_data[1] = 16'h0b22;
  beat_data[2] = 16'h0c33;
  beat_data[3] = 16'h0d44;
  for (int i = 0; i < 4; i++) begin
    beat_strb[8'(i)] = 2'b11;
  end
  write_burst(4'h3, 16'h0100, 3, BURST_INCR);
  read_burst(4'h4, 16'h0100, 3, BURST_INCR, 1'b0);
endtask

task automatic test_fixed_burst();
  test_name    = "fixed_burst";
  beat_data[0] = 16'h1111;
  beat_data[1] = 16'h2222;
  beat_data[2] = 16'h3333;
  for (int i = 0; i < 3; i++) begin
    beat_strb[8'(i)] = 2'b11;
  end
  write_burst(4'h8, 16'h0200, 2, BURST_FIXED);
  read_burst(4'h9, 16'h0200, 0, BURST_INCR, 1'b0);
endtask

task automatic test_read_stall_with_write();
  test_name = "read_stall_with_write";
  fill_words(4'ha, 16'h0300, 8);
  fork
    read_burst(4'hb, 16'h0300, 7, BURST_INCR, 1'b1);
    begin
      repeat (2) @(negedge clk);
      fill_words(4'hc, 16'h0400, 4);
    end
  join
  read_burst(4'hd, 16'h0400, 3, BURST_INCR, 1'b0);
endtask

//--- dv/axi_sram_tb.sv
module axi_sram_tb;
  import axi_sram_pkg::*;

  localparam int MEM_ADDR_BITS = 10;
  localparam int TIMEOUT       = 200;

  logic      clk;
  logic      rst_n;
  logic      aw_valid;
  logic      aw_ready;
  axi_addr_t aw;
  logic      w_valid;
  logic      w_ready;
  axi_w_t    w;
  logic      b_valid;
  logic      b_ready;
  axi_b_t    b;
  logic      ar_valid;
  logic      ar_ready;
  axi_addr_t ar;
  logic      r_valid;
  logic      r_ready;
  axi_r_t    r;

  // Expected memory contents, one word per SRAM address
  logic [AXI_DW-1:0] sb_mem [2**MEM_ADDR_BITS];
  logic [AXI_DW-1:0] beat_data [256];
  logic [STRB_W-1:0] beat_strb [256];

  string  test_name;
  int     check_errors;
  int     timeout_errors;
  integer seed;

  axi_sram_top #(
    .MEM_ADDR_BITS(MEM_ADDR_BITS)
  ) dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .aw_valid(aw_valid),
    .aw_ready(aw_ready),
    .aw      (aw),
    .w_valid (w_valid),
    .w_ready (w_ready),
    .w       (w),
    .b_valid (b_valid),
    .b_ready (b_ready),
    .b       (b),
    .ar_valid(ar_valid),
    .ar_ready(ar_ready),
    .ar      (ar),
    .r_valid (r_valid),
    .r_ready (r_ready),
    .r       (r)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_b(input string name, input axi_b_t exp, input axi_b_t act);
    if (act !== exp) begin
      check_errors++;
      $display("CHECK FAILED %s: expected id=%h resp=%h, actual id=%h resp=%h",
               name, exp.id, exp.resp, act.id, act.resp);
    end
  endtask

  function automatic string format_r(input axi_r_t beat);
    return $sformatf("id=%h data=%h resp=%h last=%b",
                     beat.id, beat.data, beat.resp, beat.last);
  endfunction

  task automatic check_r(input string name, input axi_r_t exp, input axi_r_t act);
    if (act !== exp) begin
      check_errors++;
      $display("CHECK FAILED %s: expected %s, actual %s", name, format_r(exp), format_r(act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      check_errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_errors++;
    $display("Timeout in %s: no %s within %0d cycles", test_name, what, TIMEOUT);
  endtask

  // Word address of one beat, wrapped on the memory depth
  function automatic logic [MEM_ADDR_BITS-1:0] word_index(input logic [AXI_AW-1:0] start_addr,
                                                          input int beat,
                                                          input logic [1:0] burst);
    int word;
    word = int'(start_addr >> WORD_LSB);
    if (burst != BURST_FIXED) begin
      word = word + beat;
    end
    return MEM_ADDR_BITS'(word);
  endfunction

  function automatic logic [AXI_DW-1:0] merge_bytes(input logic [AXI_DW-1:0] old_word,
                                                    input logic [AXI_DW-1:0] data,
                                                    input logic [STRB_W-1:0] strb);
    logic [AXI_DW-1:0] word;
    word = old_word;
    if (strb[0]) begin
      word[7:0] = data[7:0];
    end
    if (strb[1]) begin
      word[15:8] = data[15:8];
    end
    return word;
  endfunction

  function automatic logic [AXI_DW-1:0] fill_word(input logic [MEM_ADDR_BITS-1:0] idx);
    return 16'h5a5a ^ (16'(idx) * 16'h0d3b);
  endfunction

  task automatic send_aw(input axi_addr_t req);
    int cycles;
    cycles = 0;
    @(negedge clk);
    aw_valid = 1'b1;
    aw       = req;
    #1;
    while (!aw_ready && cycles < TIMEOUT) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (!aw_ready) begin
      report_timeout("awready");
    end
    @(negedge clk);
    aw_valid = 1'b0;
  endtask

  task automatic send_ar(input axi_addr_t req);
    int cycles;
    cycles = 0;
    @(negedge clk);
    ar_valid = 1'b1;
    ar       = req;
    #1;
    while (!ar_ready && cycles < TIMEOUT) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (!ar_ready) begin
      report_timeout("arready");
    end
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  // Beats come from beat_data and beat_strb, valid held between beats
  task automatic send_w_beats(input int len);
    int cycles;
    @(negedge clk);
    for (int i = 0; i <= len; i++) begin
      w_valid = 1'b1;
      w       = '{data: beat_data[8'(i)], strb: beat_strb[8'(i)], last: (i == len)};
      cycles  = 0;
      #1;
      while (!w_ready && cycles < TIMEOUT) begin
        @(negedge clk);
        #1;
        cycles++;
      end
      if (!w_ready) begin
        report_timeout("wready");
        break;
      end
      @(negedge clk);
    end
    w_valid = 1'b0;
  endtask

  task automatic recv_b(input logic [AXI_IW-1:0] exp_id);
    int     cycles;
    axi_b_t exp;
    exp    = '{id: exp_id, resp: 2'b00};
    cycles = 0;
    @(negedge clk);
    b_ready = 1'b1;
    #1;
    while (!b_valid && cycles < TIMEOUT) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (b_valid) begin
      check_b(test_name, exp, b);
    end else begin
      report_timeout("bvalid");
    end
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  task automatic recv_r(input logic [AXI_AW-1:0] start_addr, input int len,
                        input logic [1:0] burst, input logic [AXI_IW-1:0] exp_id,
                        input bit random_ready);
    int     cycles;
    int     beat;
    int     last_count;
    axi_r_t exp;
    cycles     = 0;
    beat       = 0;
    last_count = 0;
    while (beat <= len && cycles < TIMEOUT) begin
      @(negedge clk);
      r_ready = random_ready ? 1'($random(seed)) : 1'b1;
      #1;
      if (r_valid && r_ready) begin
        exp = '{id: exp_id, data: sb_mem[word_index(start_addr, beat, burst)],
                resp: 2'b00, last: (beat == len)};
        check_r(test_name, exp, r);
        if (r.last) begin
          last_count++;
        end
        beat++;
        cycles = 0;
      end else begin
        cycles++;
      end
    end
    if (beat <= len) begin
      report_timeout("R beat");
    end else begin
      check_bit({test_name, " rlast count"}, 1'b1, last_count == 1);
    end
    @(negedge clk);
    r_ready = 1'b0;
  endtask

  `include "axi_sram_tests.svh"

  initial begin
    seed           = 32'h969c;
    check_errors   = 0;
    timeout_errors = 0;
    test_name      = "reset";
    rst_n    = 1'b0;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar       = '0;
    r_ready  = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_reset_values();
    test_single_partial();
    test_w_before_aw();
    test_incr_burst();
    test_fixed_burst();
    test_read_stall_with_write();

    $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+dv
hdl/axi_sram_pkg.sv
hdl/axi_burst_addr.sv
hdl/axi_wr_ctrl.sv
hdl/axi_rd_ctrl.sv
hdl/sram_cmd_arb.sv
hdl/sram_model_mem.sv
hdl/axi_sram_top.sv
dv/axi_sram_tb.sv

//--- Makefile
TOP = axi_sram_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)

run: compile
	@./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
